// ==== dv/fetch_unit_properties.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module fetch_unit_properties (
  input logic        clock,
  input logic        reset,
  input logic [31:0] araddr,
  input logic        arvalid,
  input logic        arready,
  input logic        rready,
  input logic        inst_valid
);

  // read address is held until the slave takes it.
  addr_held: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr changed before arready");

  addr_line_aligned: assert property (@(posedge clock) disable iff (reset)
    arvalid |-> araddr[`IFU_OFFSET_BITS-1:0] == '0)
    else $error("araddr is not line aligned");

  // address and data phases never overlap.
  phases_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(arvalid && rready))
    else $error("arvalid and rready high in the same cycle");

  no_inst_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !inst_valid)
    else $error("inst_valid high in the first cycle after reset");

endmodule

// ==== dv/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module fetch_unit_tb;

  localparam int CLOCK_NS     = 4;
  localparam int TOTAL_INSTS  = 76;
  localparam int WORST_CYCLES = 200; // per instruction, stalls and refill included.
  localparam int WATCHDOG_NS  = (16 + TOTAL_INSTS * WORST_CYCLES) * CLOCK_NS;

  logic        clock = 1'b0;
  logic        reset;
  logic [31:0] npc;
  logic        npc_valid;
  logic        idu_ready;
  logic        block;
  logic        clear_cache;
  logic        clear_pipeline;
  logic [31:0] ifu_pc;
  logic [31:0] inst;
  logic        inst_valid;
  logic        inst_addr_misaligned;
  logic        refill_busy;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready = 1'b0;
  logic        rready;
  logic [31:0] rdata = '0;
  logic        rvalid = 1'b0;
  logic        rlast = 1'b0;

  integer      seed = 32'h35fa;
  integer      bus_seed = 32'h35fa;
  int unsigned epoch = 0;
  bit          decode_run = 1'b0;
  bit          expect_halt = 1'b0;
  bit          run_passed = 1'b0;
  bit          fail_reported = 1'b0;
  logic [31:0] exp_pc;
  logic [31:0] next_pc;
  bit          have_npc = 1'b0;
  int          consumed = 0;
  int          mis_edges = 0;
  int          reads = 0;
  int          reads_before;
  int          halt_base;
  logic [31:0] burst_addr;
  int          beat_count = 0;
  bit          burst_active = 1'b0;

  fetch_unit fetch_unit_i (
    .clock(clock), .reset(reset), .npc(npc), .npc_valid(npc_valid),
    .idu_ready(idu_ready), .block(block), .clear_cache(clear_cache),
    .clear_pipeline(clear_pipeline), .ifu_pc(ifu_pc), .inst(inst),
    .inst_valid(inst_valid), .inst_addr_misaligned(inst_addr_misaligned),
    .refill_busy(refill_busy), .araddr(araddr), .arvalid(arvalid),
    .arready(arready), .rready(rready), .rdata(rdata), .rvalid(rvalid),
    .rlast(rlast)
  );

  bind fetch_unit fetch_unit_properties properties_i (
    .clock(clock), .reset(reset), .araddr(araddr), .arvalid(arvalid),
    .arready(arready), .rready(rready), .inst_valid(inst_valid)
  );

  always #(CLOCK_NS / 2) clock = ~clock;

  // program memory contents, changed as a whole by the epoch.
  function automatic logic [31:0] mem_word(input logic [31:0] addr, input int unsigned ep);
    logic [31:0] mix;
    mix = {addr[15:0], addr[31:16]} ^ (addr * 32'h0001_0193);
    return mix ^ (32'h5bd1_e995 * (ep + 1));
  endfunction

  task automatic stop_on_error();
    fail_reported = 1'b1;
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // burst slave, bookkeeping on the rising edge.
  always @(posedge clock) begin
    if (reset) begin
      burst_active = 1'b0;
    end else begin
      // busy from the address phase through the last beat.
      assert (refill_busy == (arvalid || burst_active)) else begin
        $display("** Error at %0t ns: refill_busy %b, expected %b", $time, refill_busy,
                 arvalid || burst_active);
        stop_on_error();
      end
      if (arvalid && arready) begin
        burst_addr   = araddr;
        beat_count   = 0;
        burst_active = 1'b1;
        reads        = reads + 1;
      end else if (burst_active && rvalid && rready) begin
        beat_count = beat_count + 1;
        if (beat_count == `IFU_BURST_LEN) burst_active = 1'b0;
      end
    end
  end

  always @(negedge clock) begin
    arready = ($random(bus_seed) & 1) == 1;
    if (burst_active) begin
      rvalid = ($random(bus_seed) & 3) != 0;
      rdata  = mem_word(burst_addr + 32'(beat_count * 4), epoch);
      rlast  = (beat_count == `IFU_BURST_LEN - 1);
    end else begin
      rvalid = 1'b0;
      rdata  = '0;
      rlast  = 1'b0;
    end
  end

  // compares every consumed instruction with the reference.
  always @(posedge clock) begin
    if (reset) begin
      exp_pc   = `IFU_RESET_PC;
      have_npc = 1'b0;
    end else begin
      if (inst_valid && idu_ready && !block && !clear_pipeline) begin
        assert (!expect_halt) else begin
          $display("instruction at %h was consumed while fetch should be halted", ifu_pc);
          stop_on_error();
        end
        assert (ifu_pc == exp_pc) else begin
          $display("** Error at %0t ns: ifu_pc %h, expected %h", $time, ifu_pc, exp_pc);
          stop_on_error();
        end
        assert (inst == mem_word(exp_pc, epoch)) else begin
          $display("** Error at %0t ns: inst %h at pc %h, expected %h", $time, inst,
                   exp_pc, mem_word(exp_pc, epoch));
          stop_on_error();
        end
        exp_pc   = exp_pc + 32'd4;
        next_pc  = exp_pc;
        have_npc = 1'b1;
        consumed = consumed + 1;
      end
      if (clear_pipeline) begin
        have_npc  = 1'b0;
        mis_edges = 0;
        if (npc[1:0] == 2'b00) exp_pc = npc;
      end else if (!block) begin
        mis_edges = mis_edges + 1;
      end
    end
  end

  // one cycle of the decode model.
  task automatic tick();
    @(negedge clock);
    clear_pipeline = 1'b0;
    clear_cache    = 1'b0;
    if (decode_run) begin
      idu_ready = ($random(seed) & 3) != 0;
      block     = ($random(seed) & 7) == 0;
    end else begin
      idu_ready = 1'b0;
      block     = 1'b0;
    end
    npc_valid = have_npc;
    if (have_npc) npc = next_pc;
  endtask

  task automatic run_until(input int target);
    while (consumed < target) tick();
  endtask

  // stop decode and let any refill in flight finish.
  task automatic settle_bus();
    decode_run = 1'b0;
    tick();
    while (refill_busy) tick();
  endtask

  task automatic redirect_to(input logic [31:0] target, input logic flush);
    @(negedge clock);
    idu_ready      = 1'b0;
    block          = 1'b0;
    npc_valid      = 1'b0;
    npc            = target;
    clear_pipeline = 1'b1;
    clear_cache    = flush;
    if (flush) epoch = epoch + 1;
    decode_run = 1'b1;
  endtask

  initial begin
    reset          = 1'b1;
    npc            = '0;
    npc_valid      = 1'b0;
    idu_ready      = 1'b0;
    block          = 1'b0;
    clear_cache    = 1'b0;
    clear_pipeline = 1'b0;
    repeat (16) @(negedge clock);
    reset      = 1'b0;
    decode_run = 1'b1;
    run_until(40); // cold misses over ten lines.

    settle_bus();
    redirect_to(32'h8000_0080, 1'b0);
    reads_before = reads;
    run_until(48);
    assert (reads == reads_before) else begin
      $display("** Error at %0t ns: %0d bus reads in a loop over cached lines", $time,
               reads - reads_before);
      stop_on_error();
    end

    settle_bus();
    redirect_to(32'h8000_0080, 1'b1);
    reads_before = reads;
    run_until(60);
    assert (reads > reads_before) else begin
      $display("no refill was issued after the cache was invalidated");
      stop_on_error();
    end

    settle_bus();
    redirect_to(32'h8000_0106, 1'b0);
    expect_halt = 1'b1;
    halt_base   = consumed;
    while (!inst_addr_misaligned) tick();
    assert (mis_edges == 3) else begin
      $display("** Error at %0t ns: misaligned raised after %0d edges, expected 3", $time,
               mis_edges);
      stop_on_error();
    end
    assert (ifu_pc == 32'h8000_0106) else begin
      $display("** Error at %0t ns: ifu_pc %h on misaligned trap, expected %h", $time,
               ifu_pc, 32'h8000_0106);
      stop_on_error();
    end
    repeat (20) tick();
    assert (inst_addr_misaligned && consumed == halt_base) else begin
      $display("fetch did not stay halted after the misaligned redirect");
      stop_on_error();
    end

    settle_bus();
    redirect_to(32'h8000_0200, 1'b0);
    expect_halt = 1'b0;
    run_until(TOTAL_INSTS);
    assert (!inst_addr_misaligned) else begin
      $display("inst_addr_misaligned still high after an aligned redirect");
      stop_on_error();
    end

    run_passed = 1'b1;
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns with %0d of %0d instructions checked", WATCHDOG_NS,
             consumed, TOTAL_INSTS);
    stop_on_error();
  end

  final begin
    if (!run_passed && !fail_reported) begin
      $display("Result: FAILED");
    end
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/fetch_addr_pkg.sv
hw/icache_lines.sv
hw/line_refill.sv
hw/fetch_control.sv
hw/fetch_unit.sv
dv/fetch_unit_properties.sv
dv/fetch_unit_tb.sv

// ==== hw/fetch_addr_pkg.sv ====
`include "ifu_consts.svh"

package fetch_addr_pkg;

  // one fetch address, seen either as a plain word or split for the cache.
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [`IFU_TAG_BITS-1:0]      tag;
      logic [`IFU_INDEX_BITS-1:0]    index;
      logic [`IFU_OFFSET_BITS-3:0]   word;     // word within the line.
      logic [1:0]                    byte_sel; // nonzero means misaligned.
    } f;
  } fetch_addr_u;

endpackage

// ==== hw/fetch_control.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module fetch_control import fetch_addr_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] npc,
  input  logic        npc_valid,
  input  logic        idu_ready,
  input  logic        block,
  input  logic        clear_pipeline,
  input  logic        hit,
  input  logic [31:0] hit_word,
  input  logic        refill_done,
  output fetch_addr_u pc,
  output logic        refill_start,
  output logic [31:0] ifu_pc,
  output logic [31:0] inst,
  output logic        inst_valid,
  output logic        inst_addr_misaligned
);

  localparam logic S_LOOKUP = 1'b0;
  localparam logic S_REFILL = 1'b1;

  logic        state;
  fetch_addr_u pc_q;
  fetch_addr_u fill_pc;
  fetch_addr_u npc_a;
  logic        pipeline_empty;
  logic [3:0]  mis_q;
  logic        npc_aligned;
  logic        npc_confirms;
  logic        lookup_en;

  assign npc_a       = npc;
  assign npc_aligned = (npc_a.f.byte_sel == 2'b00);

  // during a refill the cache sees the line being filled,
  // even if a redirect has already moved the pc.
  assign pc = (state == S_REFILL) ? fill_pc : pc_q;

  assign inst_addr_misaligned = mis_q[3];

  // one lookup per cycle while decode takes instructions.
  assign lookup_en = (state == S_LOOKUP) && (mis_q == 4'b0000) && idu_ready && !block &&
                     !clear_pipeline;

  // only fetch a missing line once the pc is known to be on the right path.
  assign npc_confirms = npc_valid && (npc == pc_q.raw);
  assign refill_start = lookup_en && !hit && (pipeline_empty || npc_confirms);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_LOOKUP;
    end else if (state == S_LOOKUP) begin
      if (refill_start) state <= S_REFILL;
    end else if (refill_done) begin
      state <= S_LOOKUP; // line is complete, look it up again.
    end
  end

  always_ff @(posedge clock) begin
    if (refill_start) begin
      fill_pc <= pc_q;
    end
  end

  // pc, redirect and the misaligned delay line.
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q.raw       <= `IFU_RESET_PC;
      inst_valid     <= 1'b0;
      pipeline_empty <= 1'b1;
      mis_q          <= 4'b0000;
    end else begin
      if (!block) begin
        mis_q[3:1] <= mis_q[2:0];
      end

      if (clear_pipeline) begin
        // redirect has priority over any lookup.
        pc_q.raw       <= npc;
        inst_valid     <= 1'b0;
        pipeline_empty <= 1'b1;
        if (npc_aligned) begin
          mis_q <= 4'b0000;
        end else begin
          mis_q[0] <= 1'b1;
        end
      end else if (lookup_en) begin
        if (hit) begin
          pc_q.raw       <= pc_q.raw + 32'd4;
          inst_valid     <= 1'b1;
          pipeline_empty <= 1'b0;
        end else begin
          inst_valid <= 1'b0; // nothing to present on a miss.
        end
      end
    end
  end

  // decode output payload.
  always_ff @(posedge clock) begin
    if (clear_pipeline) begin
      if (!npc_aligned) begin
        ifu_pc <= npc; // reported with the misaligned trap.
      end
    end else if (lookup_en && hit) begin
      ifu_pc <= pc_q.raw;
      inst   <= hit_word;
    end
  end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fetch_addr_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] npc,
  input  logic        npc_valid,
  input  logic        idu_ready,
  input  logic        block,
  input  logic        clear_cache,
  input  logic        clear_pipeline,
  output logic [31:0] ifu_pc,
  output logic [31:0] inst,
  output logic        inst_valid,
  output logic        inst_addr_misaligned,
  output logic        refill_busy,
  output logic [31:0] araddr,
  output logic        arvalid,
  input  logic        arready,
  output logic        rready,
  input  logic [31:0] rdata,
  input  logic        rvalid,
  input  logic        rlast
);

  fetch_addr_u pc;
  logic        hit;
  logic [31:0] hit_word;
  logic        refill_start;
  logic        refill_done;
  logic        beat_valid;
  logic [31:0] beat_data;

  fetch_control control_i (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .npc_valid            (npc_valid),
    .idu_ready            (idu_ready),
    .block                (block),
    .clear_pipeline       (clear_pipeline),
    .hit                  (hit),
    .hit_word             (hit_word),
    .refill_done          (refill_done),
    .pc                   (pc),
    .refill_start         (refill_start),
    .ifu_pc               (ifu_pc),
    .inst                 (inst),
    .inst_valid           (inst_valid),
    .inst_addr_misaligned (inst_addr_misaligned)
  );

  icache_lines cache_i (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .invalidate (clear_cache),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .hit        (hit),
    .hit_word   (hit_word)
  );

  // the line address is the pc at the miss.
  line_refill refill_i (
    .clock        (clock),
    .reset        (reset),
    .refill_start (refill_start),
    .line_addr    (pc),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .rready       (rready),
    .arready      (arready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .rlast        (rlast),
    .beat_valid   (beat_valid),
    .beat_data    (beat_data),
    .refill_done  (refill_done),
    .refill_busy  (refill_busy)
  );

endmodule

// ==== hw/icache_lines.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module icache_lines import fetch_addr_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  fetch_addr_u pc,
  input  logic        invalidate,
  input  logic        beat_valid,
  input  logic [31:0] beat_data,
  output logic        hit,
  output logic [31:0] hit_word
);

  localparam int LINE_BITS = `IFU_LINE_WORDS * 32;

  logic [`IFU_LINES-1:0]    line_valid;
  logic [`IFU_TAG_BITS-1:0] line_tag [`IFU_LINES];
  logic [LINE_BITS-1:0]     line_data [`IFU_LINES];

  logic [`IFU_INDEX_BITS-1:0] idx;
  logic [LINE_BITS-1:0]       sel_line;

  assign idx      = pc.f.index;
  assign sel_line = line_data[idx];

  // lookup at the current pc.
  assign hit      = line_valid[idx] && (line_tag[idx] == pc.f.tag);
  assign hit_word = sel_line[{pc.f.word, 5'b00000} +: 32];

  // valid bits. a fill beat wins over an invalidate in the same cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else begin
      if (invalidate) begin
        line_valid <= '0;
      end
      if (beat_valid) begin
        line_valid[idx] <= 1'b1;
      end
    end
  end

  // beats arrive lowest word first and shift in from the top,
  // so the line is in order after the last one.
  always_ff @(posedge clock) begin
    if (beat_valid) begin
      line_tag[idx]  <= pc.f.tag;
      line_data[idx] <= {beat_data, line_data[idx][LINE_BITS-1:32]};
    end
  end

endmodule

// ==== hw/ifu_consts.svh ====
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// byte offset inside one cache line.
`define IFU_OFFSET_BITS 4

// line index width.
`define IFU_INDEX_BITS 2

`define IFU_LINES (1 << `IFU_INDEX_BITS)

// 32-bit words per line, one per burst beat.
`define IFU_LINE_WORDS 4

// address bits above the index.
`define IFU_TAG_BITS (32 - `IFU_INDEX_BITS - `IFU_OFFSET_BITS)

`define IFU_RESET_PC 32'h8000_0000

// beats in one refill burst.
`define IFU_BURST_LEN `IFU_LINE_WORDS

`endif

// ==== hw/line_refill.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module line_refill import fetch_addr_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        refill_start,
  input  fetch_addr_u line_addr,
  output logic [31:0] araddr,
  output logic        arvalid,
  output logic        rready,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic        rvalid,
  input  logic        rlast,
  output logic        beat_valid,
  output logic [31:0] beat_data,
  output logic        refill_done,
  output logic        refill_busy
);

  localparam logic [1:0] R_IDLE = 2'd0;
  localparam logic [1:0] R_ADDR = 2'd1;
  localparam logic [1:0] R_DATA = 2'd2;

  logic [1:0] state;

  assign arvalid     = (state == R_ADDR);
  assign rready      = (state == R_DATA);
  assign refill_busy = (state != R_IDLE);

  // every accepted beat goes straight to the cache.
  assign beat_valid  = rready && rvalid;
  assign beat_data   = rdata;
  assign refill_done = beat_valid && rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= R_IDLE;
    end else begin
      case (state)
        R_IDLE: begin
          if (refill_start) state <= R_ADDR;
        end
        R_ADDR: begin
          if (arready) state <= R_DATA; // address taken.
        end
        R_DATA: begin
          if (refill_done) state <= R_IDLE;
        end
        default: begin
          state <= R_IDLE;
        end
      endcase
    end
  end

  // line aligned address, held while arvalid is up.
  always_ff @(posedge clock) begin
    if (state == R_IDLE && refill_start) begin
      araddr <= {line_addr.f.tag, line_addr.f.index, {`IFU_OFFSET_BITS{1'b0}}};
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module fetch_unit_tb \
  -f filelist.f \
  -o fetch_unit_sim

status=0
output=$(./obj_dir/fetch_unit_sim 2>&1) || status=$?
echo "$output"

if grep -qx "Result: PASSED" <<< "$output"; then
  exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
